// File: Bender.yml
package:
  name: lsu

sources:
  - logic/lsu_pkg.sv
  - logic/store_queue.sv
  - logic/l1d_cache.sv
  - logic/load_unit.sv
  - logic/store_writer.sv
  - logic/lsu.sv
  - target: test
    files:
      - bench/lsu_props.sv
      - bench/lsu_tb.sv

// File: bench/lsu_props.sv
`timescale 1ns/10ps

module lsu_props (
  input logic clock,
  input logic reset,
  input logic req,
  input logic resp,
  input logic abort,
  input logic done
);
  int fails = 0;

  done_pulse: assert property (@(posedge clock) disable iff (reset) done |=> !done)
    else begin
      fails++;
      $error("completion pulse lasted more than one cycle");
    end

  // request held until answered or flushed
  req_hold: assert property (@(posedge clock) disable iff (reset)
    req && !resp && !abort |=> req)
    else begin
      fails++;
      $error("request dropped before its response");
    end

  idle_after_reset: assert property (@(posedge clock) reset |=> !req)
    else begin
      fails++;
      $error("request high in the cycle after reset");
    end

endmodule

bind load_unit lsu_props i_props (
  .clock, .reset, .req(arvalid), .resp(rvalid), .abort(flush_pipeline), .done(load_valid)
);

bind store_writer lsu_props i_props (
  .clock, .reset, .req(awvalid), .resp(wready), .abort(1'b0), .done(pop)
);

// File: bench/lsu_tb.sv
`timescale 1ns/10ps

module lsu_tb;
  import lsu_pkg::*;

  localparam int n_ops = 300;
  localparam int worst_cycles = 80;

  logic        clock = 1'b0;
  logic        reset;
  logic        flush_pipeline;
  logic        fence_time;
  logic        ren;
  logic [31:0] raddr;
  mem_op_t     rop;
  logic [31:0] load_data;
  logic        load_valid;
  logic        commit_valid;
  mem_op_t     commit_op;
  logic [31:0] commit_addr;
  logic [31:0] commit_data;
  logic        sq_ready;
  logic        arvalid;
  logic [31:0] araddr;
  logic [3:0]  rstrb;
  logic        rvalid;
  logic [31:0] rdata;
  logic        awvalid;
  logic        wvalid;
  logic [31:0] awaddr;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wready;

  logic [31:0] bus_mem [80]; // words 0..63 cacheable, 64..79 device
  logic [31:0] ref_mem [80]; // as committed
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [3:0]  exp_strb [$];
  logic [29:0] pend_word [$]; // entries still in the queue
  logic        known_v [16];
  logic [25:0] known_tag [16];
  int unsigned seed = 33752;
  logic        rd_busy = 1'b0;
  logic [31:0] rd_addr;
  int          rd_wait = 0;
  int          wr_wait = 0;
  logic        pop_due = 1'b0;
  logic        ar_seen = 1'b0;

  lsu i_lsu (.*);

  always #10 clock = ~clock;

  function automatic int unsigned next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed >> 12;
  endfunction

  function automatic int word_slot(input logic [31:0] addr);
    if (addr[31:28] == 4'h1) return 64 + addr[5:2];
    return addr[7:2];
  endfunction

  function automatic int op_bytes(input mem_op_t op);
    if (op == lb || op == lbu || op == sb) return 1;
    if (op == lh || op == lhu || op == sh) return 2;
    return 4;
  endfunction

  function automatic logic [3:0] lanes(input mem_op_t op, input logic [1:0] off);
    return 4'((1 << op_bytes(op)) - 1) << off;
  endfunction

  function automatic logic [31:0] byte_mask(input logic [3:0] strb);
    logic [31:0] m;
    for (int b = 0; b < 4; b++) m[8*b +: 8] = {8{strb[b]}};
    return m;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr * 32'h9e37_79b9 + {addr[15:0], addr[31:16]};
  endfunction

  function automatic logic [31:0] random_addr(input mem_op_t op);
    int unsigned r;
    logic [31:0] a;
    r = next_rand();
    if (r % 4 == 0) a = 32'h1000_0000 + (r / 4) % 64;
    else a = 32'h8000_0000 + (r / 4) % 256;
    return a & ~32'(op_bytes(op) - 1);
  endfunction

  // value a load should return from a committed word
  function automatic logic [31:0] extend(input mem_op_t op, input logic [31:0] word,
                                         input logic [1:0] off);
    logic [31:0] v;
    v = word >> (8 * off);
    case (op)
      lb:      return {{24{v[7]}}, v[7:0]};
      lbu:     return {24'h0, v[7:0]};
      lh:      return {{16{v[15]}}, v[15:0]};
      lhu:     return {16'h0, v[15:0]};
      default: return v;
    endcase
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic commit_store(input mem_op_t op, input logic [31:0] a);
    logic [31:0] d;
    logic [3:0]  m;
    logic        ready_exp;
    logic        accepted;
    int          s;
    d = next_rand() ^ (next_rand() << 16);
    if (op_bytes(op) < 4) d = d & ((32'h1 << (8 * op_bytes(op))) - 1);
    m = lanes(op, a[1:0]);
    s = word_slot(a);
    commit_valid = 1'b1;
    commit_op = op;
    commit_addr = a;
    commit_data = d;
    accepted = 1'b0;
    while (!accepted) begin
      #1;
      ready_exp = pend_word.size() < 4;
      foreach (pend_word[i]) if (pend_word[i] == a[31:2]) ready_exp = 1'b0;
      assert (sq_ready == ready_exp)
        else stop_run($sformatf("error sq_ready: got %h expected %h", sq_ready, ready_exp));
      accepted = sq_ready;
      @(negedge clock);
    end
    commit_valid = 1'b0;
    exp_addr.push_back({a[31:2], 2'b00});
    exp_data.push_back(d << (8 * a[1:0]));
    exp_strb.push_back(m);
    pend_word.push_back(a[31:2]);
    ref_mem[s] = (ref_mem[s] & ~byte_mask(m)) | ((d << (8 * a[1:0])) & byte_mask(m));
    if (a[31:28] != 4'h1) begin
      if (op == sw) begin
        known_v[a[5:2]] = 1'b1;
        known_tag[a[5:2]] = a[31:6];
      end else if (known_tag[a[5:2]] != a[31:6]) begin
        known_v[a[5:2]] = 1'b0; // another word on that line
      end
    end
  endtask

  task automatic run_load(input mem_op_t op, input logic [31:0] a, input logic flush_it,
                          input logic bus_exp);
    logic [31:0] expv;
    logic        cache_exp;
    cache_exp = a[31:28] != 4'h1 && known_v[a[5:2]] && known_tag[a[5:2]] == a[31:6];
    expv = extend(op, ref_mem[word_slot(a)], a[1:0]);
    ar_seen = 1'b0;
    ren = 1'b1;
    raddr = a;
    rop = op;
    if (flush_it) begin
      while (!arvalid) @(negedge clock);
      flush_pipeline = 1'b1;
      ren = 1'b0;
      @(negedge clock);
      flush_pipeline = 1'b0;
      repeat (6) begin
        assert (!load_valid) else stop_run("load_valid seen after a flushed bus read");
        @(negedge clock);
      end
    end else begin
      do @(negedge clock); while (!load_valid);
      assert (load_data == expv)
        else stop_run($sformatf("error load_data: got %h expected %h", load_data, expv));
      ren = 1'b0;
      if (cache_exp) assert (!ar_seen) else stop_run("a cached word was read over the bus");
      if (bus_exp) assert (ar_seen) else stop_run("a load that must use the bus did not");
      if (ar_seen && a[31:28] != 4'h1) begin
        known_v[a[5:2]] = 1'b1;
        known_tag[a[5:2]] = a[31:6];
      end
    end
  endtask

  // bus responders
  always @(negedge clock) begin
    rvalid = 1'b0;
    if (!rd_busy && arvalid) begin
      assert (araddr[31:2] == raddr[31:2])
        else stop_run($sformatf("error araddr: got %h expected %h", araddr, raddr));
      assert (rstrb == lanes(rop, raddr[1:0]))
        else stop_run($sformatf("error rstrb: got %h expected %h", rstrb,
                                lanes(rop, raddr[1:0])));
      rd_busy = 1'b1;
      rd_addr = araddr;
      rd_wait = next_rand() % 4;
    end
    if (rd_busy) begin
      if (rd_wait == 0) begin
        rvalid = 1'b1;
        rdata = bus_mem[word_slot(rd_addr)];
        rd_busy = 1'b0;
      end else rd_wait--;
    end
    if (wready) begin
      wready = 1'b0;
    end else if (wvalid) begin
      if (wr_wait == 0) begin
        wready = 1'b1;
        wr_wait = next_rand() % 4;
      end else wr_wait--;
    end
  end

  always @(posedge clock) begin
    if (arvalid) ar_seen = 1'b1;
    if (pop_due) void'(pend_word.pop_front()); // entry leaves the cycle after its write
    pop_due = 1'b0;
    if (wvalid && wready) begin
      assert (awvalid && exp_addr.size() > 0) else stop_run("write seen with no store pending");
      assert (awaddr == exp_addr[0])
        else stop_run($sformatf("error awaddr: got %h expected %h", awaddr, exp_addr[0]));
      assert (wdata == exp_data[0])
        else stop_run($sformatf("error wdata: got %h expected %h", wdata, exp_data[0]));
      assert (wstrb == exp_strb[0])
        else stop_run($sformatf("error wstrb: got %h expected %h", wstrb, exp_strb[0]));
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
      void'(exp_strb.pop_front());
      bus_mem[word_slot(awaddr)] = (bus_mem[word_slot(awaddr)] & ~byte_mask(wstrb))
                                   | (wdata & byte_mask(wstrb));
      pop_due = 1'b1;
    end
  end

  initial begin
    #(n_ops * worst_cycles * 20);
    stop_run("timeout: the test did not finish in time");
  end

  initial begin
    int unsigned r;
    logic [31:0] a;
    mem_op_t     op;
    reset = 1'b1;
    flush_pipeline = 1'b0;
    fence_time = 1'b0;
    ren = 1'b0;
    raddr = 32'h8000_0000;
    rop = lw;
    commit_valid = 1'b0;
    commit_op = sw;
    commit_addr = '0;
    commit_data = '0;
    rvalid = 1'b0;
    rdata = '0;
    wready = 1'b0;
    for (int i = 0; i < 80; i++) begin
      a = (i < 64) ? 32'h8000_0000 + 4 * i : 32'h1000_0000 + 4 * (i - 64);
      bus_mem[i] = fill_word(a);
      ref_mem[i] = fill_word(a);
    end
    for (int i = 0; i < 16; i++) known_v[i] = 1'b0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    for (int n = 0; n < n_ops; n++) begin
      r = next_rand() % 16;
      if (r < 6) begin
        repeat (1 + next_rand() % 4) begin
          op = mem_op_t'(5 + next_rand() % 3);
          commit_store(op, random_addr(op));
        end
      end else if (r < 13) begin
        op = mem_op_t'(next_rand() % 5);
        a = random_addr(op);
        run_load(op, a, 1'b0, a[31:28] == 4'h1);
      end else if (r == 13) begin
        op = mem_op_t'(next_rand() % 5);
        run_load(op, 32'h1000_0000 | (random_addr(op) & 32'h3f), 1'b1, 1'b1);
      end else if (r == 14) begin
        while (pend_word.size() != 0) @(negedge clock);
        fence_time = 1'b1;
        @(negedge clock);
        fence_time = 1'b0;
        for (int i = 0; i < 16; i++) known_v[i] = 1'b0;
        op = mem_op_t'(next_rand() % 5);
        run_load(op, 32'h8000_0000 | (random_addr(op) & 32'hff), 1'b0, 1'b1);
      end else begin
        // word store then a load from inside it
        a = random_addr(sw);
        commit_store(sw, a);
        op = mem_op_t'(next_rand() % 5);
        a = (a | (next_rand() % 4)) & ~32'(op_bytes(op) - 1);
        run_load(op, a, 1'b0, a[31:28] == 4'h1);
      end
    end

    while (pend_word.size() != 0) @(negedge clock);
    repeat (4) @(negedge clock);
    if (i_lsu.i_load_unit.i_props.fails + i_lsu.i_store_writer.i_props.fails == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stop_run("a bound assertion failed during the run");
    end
  end

endmodule

// File: logic/l1d_cache.sv
`timescale 1ns/10ps

module l1d_cache (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     fence_time,
  input  logic [lsu_pkg::xlen-1:0] lookup_addr,
  output logic                     hit,
  output logic [lsu_pkg::xlen-1:0] line_data,
  input  logic                     fill_en,
  input  logic [lsu_pkg::xlen-1:0] fill_data,
  input  logic                     st_en,
  input  logic [lsu_pkg::xlen-1:0] st_addr,
  input  logic [lsu_pkg::xlen-1:0] st_data,
  input  logic [3:0]               st_strb,
  input  logic                     st_alloc
);
  import lsu_pkg::*;

  localparam int lines = 2 ** l1d_idx_w;

  logic [xlen-1:0]      data_arr [lines];
  logic [l1d_tag_w-1:0] tag_arr  [lines];
  logic [lines-1:0]     line_valid;

  logic [l1d_idx_w-1:0] lk_idx;
  logic [l1d_tag_w-1:0] lk_tag;
  logic [l1d_idx_w-1:0] st_idx;
  logic [l1d_tag_w-1:0] st_tag;
  logic                 st_hit;
  logic                 do_fill;

  assign lk_idx = lookup_addr[l1d_idx_w+1:2];
  assign lk_tag = lookup_addr[xlen-1:l1d_idx_w+2];
  assign st_idx = st_addr[l1d_idx_w+1:2];
  assign st_tag = st_addr[xlen-1:l1d_idx_w+2];

  assign hit = line_valid[lk_idx] && tag_arr[lk_idx] == lk_tag;
  assign line_data = data_arr[lk_idx];
  assign st_hit = line_valid[st_idx] && tag_arr[st_idx] == st_tag;

  // a store to the same line wins over the refill
  assign do_fill = fill_en && !(st_en && st_idx == lk_idx);

  always_ff @(posedge clock) begin
    if (reset || fence_time) begin
      line_valid <= '0;
    end else begin
      if (do_fill) line_valid[lk_idx] <= 1'b1;
      if (st_en && st_alloc) line_valid[st_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (do_fill) begin
      data_arr[lk_idx] <= fill_data;
      tag_arr[lk_idx] <= lk_tag;
    end
    if (st_en && st_alloc) begin
      data_arr[st_idx] <= st_data;
      tag_arr[st_idx] <= st_tag;
    end else if (st_en && st_hit) begin
      for (int b = 0; b < 4; b++) begin
        if (st_strb[b]) data_arr[st_idx][8*b +: 8] <= st_data[8*b +: 8]; // byte merge
      end
    end
  end

endmodule

// File: logic/load_unit.sv
`timescale 1ns/10ps

module load_unit (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     flush_pipeline,
  input  logic                     ren,
  input  logic [lsu_pkg::xlen-1:0] raddr,
  input  lsu_pkg::mem_op_t         rop,
  input  logic                     sq_empty,
  input  logic                     fwd_hit,
  input  logic [lsu_pkg::xlen-1:0] fwd_data,
  input  logic                     hit,
  input  logic [lsu_pkg::xlen-1:0] line_data,
  output logic                     fill_en,
  output logic [lsu_pkg::xlen-1:0] fill_data,
  output logic                     arvalid,
  output logic [lsu_pkg::xlen-1:0] araddr,
  output logic [3:0]               rstrb,
  input  logic                     rvalid,
  input  logic [lsu_pkg::xlen-1:0] rdata,
  output logic [lsu_pkg::xlen-1:0] load_data,
  output logic                     load_valid
);
  import lsu_pkg::*;

  load_state_t     state;
  logic [xlen-1:0] word_q; // chosen word before the lane shift
  logic [xlen-1:0] shifted;
  logic            uncached;
  logic            fwd_ok;
  logic            hit_ok;

  assign uncached = is_uncacheable(raddr);
  // device reads always go to the bus
  assign fwd_ok = fwd_hit && !uncached;
  assign hit_ok = sq_empty && hit && !uncached;

  assign arvalid = state == ld_bus;
  assign araddr = raddr;
  assign rstrb = byte_strb(rop, raddr[1:0]);

  assign fill_en = state == ld_bus && rvalid && !flush_pipeline && !uncached;
  assign fill_data = rdata;

  assign load_valid = state == ld_done;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ld_idle;
    end else begin
      case (state)
        ld_idle: begin
          if (ren && !flush_pipeline) begin
            if (fwd_ok || hit_ok) state <= ld_done;
            else if (sq_empty) state <= ld_bus; // wait for queue to drain
          end
        end
        ld_bus: begin
          if (flush_pipeline) state <= ld_idle;
          else if (rvalid) state <= ld_done;
        end
        default: state <= ld_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == ld_idle) begin
      if (fwd_ok) word_q <= fwd_data;
      else word_q <= line_data;
    end else if (state == ld_bus && rvalid) begin
      word_q <= rdata;
    end
  end

  assign shifted = word_q >> {raddr[1:0], 3'b000};

  always_comb begin
    case (rop)
      lb:      load_data = {{(xlen-8){shifted[7]}}, shifted[7:0]};
      lbu:     load_data = {{(xlen-8){1'b0}}, shifted[7:0]};
      lh:      load_data = {{(xlen-16){shifted[15]}}, shifted[15:0]};
      lhu:     load_data = {{(xlen-16){1'b0}}, shifted[15:0]};
      default: load_data = shifted;
    endcase
  end

endmodule

// File: logic/lsu.sv
`timescale 1ns/10ps

module lsu (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     flush_pipeline,
  input  logic                     fence_time,
  input  logic                     ren,
  input  logic [lsu_pkg::xlen-1:0] raddr,
  input  lsu_pkg::mem_op_t         rop,
  output logic [lsu_pkg::xlen-1:0] load_data,
  output logic                     load_valid,
  input  logic                     commit_valid,
  input  lsu_pkg::mem_op_t         commit_op,
  input  logic [lsu_pkg::xlen-1:0] commit_addr,
  input  logic [lsu_pkg::xlen-1:0] commit_data,
  output logic                     sq_ready,
  output logic                     arvalid,
  output logic [lsu_pkg::xlen-1:0] araddr,
  output logic [3:0]               rstrb,
  input  logic                     rvalid,
  input  logic [lsu_pkg::xlen-1:0] rdata,
  output logic                     awvalid,
  output logic                     wvalid,
  output logic [lsu_pkg::xlen-1:0] awaddr,
  output logic [lsu_pkg::xlen-1:0] wdata,
  output logic [3:0]               wstrb,
  input  logic                     wready
);
  import lsu_pkg::*;

  logic            head_valid;
  logic [xlen-1:0] head_addr;
  logic [xlen-1:0] head_data;
  logic [3:0]      head_strb;
  mem_op_t         head_op;
  logic            pop;
  logic            sq_empty;
  logic            fwd_hit;
  logic [xlen-1:0] fwd_data;
  logic            hit;
  logic [xlen-1:0] line_data;
  logic            fill_en;
  logic [xlen-1:0] fill_data;
  logic            st_en;
  logic [xlen-1:0] st_addr;
  logic [xlen-1:0] st_data;
  logic [3:0]      st_strb;
  logic            st_alloc;

  store_queue i_store_queue (
    .clock, .reset, .commit_valid, .commit_op, .commit_addr, .commit_data, .sq_ready,
    .raddr, .pop, .head_valid, .head_addr, .head_data, .head_strb, .head_op,
    .sq_empty, .fwd_hit, .fwd_data
  );

  // lookup follows the held load address
  l1d_cache i_l1d_cache (
    .clock, .reset, .fence_time, .lookup_addr(raddr), .hit, .line_data,
    .fill_en, .fill_data, .st_en, .st_addr, .st_data, .st_strb, .st_alloc
  );

  load_unit i_load_unit (
    .clock, .reset, .flush_pipeline, .ren, .raddr, .rop, .sq_empty, .fwd_hit, .fwd_data,
    .hit, .line_data, .fill_en, .fill_data, .arvalid, .araddr, .rstrb, .rvalid, .rdata,
    .load_data, .load_valid
  );

  store_writer i_store_writer (
    .clock, .reset, .head_valid, .head_addr, .head_data, .head_strb, .head_op, .pop,
    .awvalid, .wvalid, .awaddr, .wdata, .wstrb, .wready,
    .st_en, .st_addr, .st_data, .st_strb, .st_alloc
  );

endmodule

// File: logic/lsu_pkg.sv
package lsu_pkg;

  localparam int xlen = 32;
  localparam int sq_depth = 4;
  localparam int sq_idx_w = 2;

  // 16 lines of one word each
  localparam int l1d_idx_w = 4;
  localparam int l1d_tag_w = xlen - l1d_idx_w - 2;

  // device window 0x1xxxxxxx is never cached
  localparam logic [xlen-1:0] dev_base = 32'h1000_0000;
  localparam logic [xlen-1:0] dev_mask = 32'hf000_0000;

  typedef enum logic [3:0] {
    lb, lbu, lh, lhu, lw, sb, sh, sw
  } mem_op_t;

  typedef enum logic [1:0] {
    ld_idle, ld_bus, ld_done
  } load_state_t;

  typedef enum logic {
    st_send, st_ack
  } store_state_t;

  function automatic logic is_uncacheable(input logic [xlen-1:0] addr);
    return (addr & dev_mask) == dev_base;
  endfunction

  // lane mask for an aligned access of op at byte offset
  function automatic logic [3:0] byte_strb(input mem_op_t op, input logic [1:0] offset);
    case (op)
      lb, lbu, sb: return 4'b0001 << offset;
      lh, lhu, sh: return 4'b0011 << offset;
      default:     return 4'b1111;
    endcase
  endfunction

endpackage

// File: logic/store_queue.sv
`timescale 1ns/10ps

module store_queue (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     commit_valid,
  input  lsu_pkg::mem_op_t         commit_op,
  input  logic [lsu_pkg::xlen-1:0] commit_addr,
  input  logic [lsu_pkg::xlen-1:0] commit_data,
  output logic                     sq_ready,
  input  logic [lsu_pkg::xlen-1:0] raddr,
  input  logic                     pop,
  output logic                     head_valid,
  output logic [lsu_pkg::xlen-1:0] head_addr,
  output logic [lsu_pkg::xlen-1:0] head_data,
  output logic [3:0]               head_strb,
  output lsu_pkg::mem_op_t         head_op,
  output logic                     sq_empty,
  output logic                     fwd_hit,
  output logic [lsu_pkg::xlen-1:0] fwd_data
);
  import lsu_pkg::*;

  logic [sq_depth-1:0] q_valid;
  logic [xlen-1:0]     q_addr [sq_depth];
  logic [xlen-1:0]     q_data [sq_depth];
  logic [3:0]          q_strb [sq_depth];
  mem_op_t             q_op   [sq_depth];
  logic [sq_idx_w-1:0] head_ptr;
  logic [sq_idx_w-1:0] tail_ptr;
  logic                dup_word;
  logic                push;

  assign push = commit_valid && sq_ready;
  assign sq_ready = !q_valid[tail_ptr] && !dup_word;
  assign sq_empty = ~|q_valid;

  assign head_valid = q_valid[head_ptr];
  assign head_addr = q_addr[head_ptr];
  assign head_data = q_data[head_ptr];
  assign head_strb = q_strb[head_ptr];
  assign head_op = q_op[head_ptr];

  // word match against load address and incoming store
  always_comb begin
    fwd_hit = 1'b0;
    fwd_data = '0;
    dup_word = 1'b0;
    for (int i = 0; i < sq_depth; i++) begin
      if (q_valid[i] && q_op[i] == sw && q_addr[i][xlen-1:2] == raddr[xlen-1:2]) begin
        fwd_hit = 1'b1;
        fwd_data = q_data[i];
      end
      if (q_valid[i] && q_addr[i][xlen-1:2] == commit_addr[xlen-1:2]) begin
        dup_word = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      q_valid <= '0;
      head_ptr <= '0;
      tail_ptr <= '0;
    end else begin
      if (push) begin
        q_valid[tail_ptr] <= 1'b1;
        tail_ptr <= tail_ptr + 1'b1;
      end
      if (pop && head_valid) begin
        q_valid[head_ptr] <= 1'b0;
        head_ptr <= head_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      q_addr[tail_ptr] <= {commit_addr[xlen-1:2], 2'b00};
      q_data[tail_ptr] <= commit_data << {commit_addr[1:0], 3'b000}; // onto its lane
      q_strb[tail_ptr] <= byte_strb(commit_op, commit_addr[1:0]);
      q_op[tail_ptr] <= commit_op;
    end
  end

endmodule

// File: logic/store_writer.sv
`timescale 1ns/10ps

module store_writer (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     head_valid,
  input  logic [lsu_pkg::xlen-1:0] head_addr,
  input  logic [lsu_pkg::xlen-1:0] head_data,
  input  logic [3:0]               head_strb,
  input  lsu_pkg::mem_op_t         head_op,
  output logic                     pop,
  output logic                     awvalid,
  output logic                     wvalid,
  output logic [lsu_pkg::xlen-1:0] awaddr,
  output logic [lsu_pkg::xlen-1:0] wdata,
  output logic [3:0]               wstrb,
  input  logic                     wready,
  output logic                     st_en,
  output logic [lsu_pkg::xlen-1:0] st_addr,
  output logic [lsu_pkg::xlen-1:0] st_data,
  output logic [3:0]               st_strb,
  output logic                     st_alloc
);
  import lsu_pkg::*;

  store_state_t state;

  assign awvalid = head_valid && state == st_send;
  assign wvalid = head_valid && state == st_send;
  assign awaddr = head_addr;
  assign wdata = head_data;
  assign wstrb = head_strb;

  // head stays put until the pop edge
  assign pop = state == st_ack;
  assign st_en = state == st_ack && !is_uncacheable(head_addr);
  assign st_alloc = head_op == sw;
  assign st_addr = head_addr;
  assign st_data = head_data;
  assign st_strb = head_strb;

  always_ff @(posedge clock) begin
    if (reset) state <= st_send;
    else if (state == st_send && head_valid && wready) state <= st_ack;
    else if (state == st_ack) state <= st_send;
  end

endmodule

// File: lsu.f
logic/lsu_pkg.sv
logic/store_queue.sv
logic/l1d_cache.sv
logic/load_unit.sv
logic/store_writer.sv
logic/lsu.sv
bench/lsu_props.sv
bench/lsu_tb.sv
